// File: Makefile
SIM = obj_dir/camera_config_tb

.PHONY: build run clean

build:
	verilator --binary --timing --top-module camera_config_tb -f sim.f -o camera_config_tb

run: build
	./$(SIM)

clean:
	rm -rf obj_dir

// File: bench/camera_config_tb.sv
`timescale 1ns/1ps
`include "cam_cfg_macros.svh"

module camera_config_tb;
   import cam_cfg_pkg::*;

   logic        CLK_400K = 1'b0;
   logic        RESET_N = 1'b0;
   logic        i2c_scl;
   logic        i2c_sda_low;
   logic        i2c_sda_in;
   logic [7:0]  sensor_id;
   logic        camera_released;
   logic        model_sda_low;
   logic        start_seen;
   logic        stop_seen;
   logic        wr_valid;
   logic [6:0]  wr_dev;
   logic [15:0] wr_reg;
   logic [7:0]  wr_data;
   logic        id_good_sent;
   int          id_reads;
   int          addr_nacks = 1;
   int          bad_ids = 1;
   int          seed;
   int          ref_idx = 0;
   int          writes_seen = 0;

   assign i2c_sda_in = !i2c_sda_low && !model_sda_low;   // open-drain bus

   always #2 CLK_400K = ~CLK_400K;

   camera_config_top dut (
      .CLK_400K        (CLK_400K),
      .RESET_N         (RESET_N),
      .i2c_scl         (i2c_scl),
      .i2c_sda_low     (i2c_sda_low),
      .i2c_sda_in      (i2c_sda_in),
      .sensor_id       (sensor_id),
      .camera_released (camera_released)
   );

   i2c_sensor_model sensor (
      .clk          (CLK_400K),
      .scl          (i2c_scl),
      .sda          (i2c_sda_in),
      .sda_low      (model_sda_low),
      .addr_nacks   (addr_nacks),
      .bad_ids      (bad_ids),
      .start_seen   (start_seen),
      .stop_seen    (stop_seen),
      .wr_valid     (wr_valid),
      .wr_dev       (wr_dev),
      .wr_reg       (wr_reg),
      .wr_data      (wr_data),
      .id_reads     (id_reads),
      .id_good_sent (id_good_sent)
   );

   // expected script, {register, data} per entry
   function automatic script_entry_t script_ref(input int idx);
      script_entry_t e;
      logic [23:0]   w;
      e.kind = ENTRY_WRITE;
      case (idx)
         0, 1:    w = 24'h0103_01;
         2, 20: begin
            e.kind = ENTRY_DELAY;
            w      = 24'h0000_0a;
         end
         3, 4:    w = 24'h0100_00;
         5:       w = 24'h0302_18;
         6:       w = 24'h0303_00;
         7:       w = 24'h0304_03;
         8:       w = 24'h030e_00;
         9:       w = 24'h030f_04;
         10:      w = 24'h0312_01;
         11:      w = 24'h031e_0c;
         12:      w = 24'h3015_01;
         13:      w = 24'h3808_02;
         14:      w = 24'h3809_80;
         15:      w = 24'h380a_01;
         16:      w = 24'h380b_e0;
         17:      w = 24'h5018_19;
         18:      w = 24'h501a_10;
         19:      w = 24'h501c_17;
         21:      w = 24'h5000_16;
         22:      w = 24'h5001_01;
         default: w = 24'h0100_01;
      endcase
      e.reg_addr = w[23:8];
      e.data     = w[7:0];
      return e;
   endfunction

   task automatic stop_run();
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic fail_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
      $display("[ERROR] t=%0t %s got %0h expected %0h", $time, sig, got, exp);
      stop_run();
   endtask

   task automatic fail_text(input string msg);
      $display("[ERROR] t=%0t %s", $time, msg);
      stop_run();
   endtask

   task automatic check_idle();
      assert (i2c_scl === 1'b1) else fail_value("i2c_scl", i2c_scl, 1);
      assert (i2c_sda_low === 1'b0) else fail_value("i2c_sda_low", i2c_sda_low, 0);
      assert (camera_released === 1'b0) else fail_value("camera_released", camera_released, 0);
   endtask

   // write log against the script, idle gaps, release ordering
   initial begin : compare
      script_entry_t exp;
      int            cycle;
      int            stop_cycle;
      int            req_gap;
      logic          rel_q;
      cycle      = 0;
      stop_cycle = 0;
      req_gap    = 0;
      rel_q      = 1'b0;
      forever begin
         @(posedge CLK_400K);
         #1;
         cycle++;
         if (start_seen === 1'b1 && req_gap > 0) begin
            assert (cycle - stop_cycle >= req_gap)
               else fail_value("idle cycles before START", cycle - stop_cycle, req_gap);
            req_gap = 0;
         end
         if (stop_seen === 1'b1)
            stop_cycle = cycle;
         if (wr_valid === 1'b1) begin
            assert (id_good_sent) else fail_text("register write before the good ID answer");
            assert (ref_idx < `CFG_SCRIPT_LEN) else fail_text("more writes than script entries");
            exp = script_ref(ref_idx);
            assert (wr_dev == 7'h36) else fail_value("wr_dev", wr_dev, 7'h36);
            assert (wr_reg == exp.reg_addr) else fail_value("wr_reg", wr_reg, exp.reg_addr);
            assert (wr_data == exp.data) else fail_value("wr_data", wr_data, exp.data);
            writes_seen++;
            ref_idx++;
            req_gap = 0;
            exp     = script_ref(ref_idx);
            while (ref_idx < `CFG_SCRIPT_LEN && exp.kind == ENTRY_DELAY) begin
               req_gap += exp.data;
               ref_idx++;
               exp = script_ref(ref_idx);
            end
            if (req_gap > 0)
               req_gap += `CFG_GAP_CYCLES;
         end
         if (camera_released === 1'b1 && rel_q !== 1'b1) begin
            assert (ref_idx == `CFG_SCRIPT_LEN && wr_reg == 16'h0100 && wr_data == 8'h01)
               else fail_text("camera released before the last script write");
         end
         rel_q = camera_released;
      end
   end

   initial begin : main
      script_entry_t e;
      int            n;
      int            i;
      int            exp_writes;
      seed       = 28;
      bad_ids    = 1 + ($unsigned($random(seed)) % 3);
      exp_writes = 0;
      for (i = 0; i < `CFG_SCRIPT_LEN; i++) begin
         e = script_ref(i);
         if (e.kind == ENTRY_WRITE)
            exp_writes++;
      end
      repeat (4) begin
         @(posedge CLK_400K);
         #1;
         check_idle();
      end
      RESET_N = 1'b1;
      repeat (4) begin
         check_idle();
         @(posedge CLK_400K);
         #1;
      end
      n = 0;
      while (camera_released !== 1'b1) begin
         @(posedge CLK_400K);
         #1;
         n++;
         if (n > 40000)
            fail_text("timeout waiting for camera_released");
      end
      assert (sensor_id == 8'h88) else fail_value("sensor_id", sensor_id, 8'h88);
      assert (id_reads == bad_ids + 2) else fail_value("id_reads", id_reads, bad_ids + 2);
      assert (writes_seen == exp_writes)
         else fail_value("writes_seen", writes_seen, exp_writes);
      repeat (200) begin                       // bus must stay quiet
         @(posedge CLK_400K);
         #1;
         assert (start_seen !== 1'b1) else fail_text("START seen after camera release");
         assert (i2c_scl === 1'b1) else fail_value("i2c_scl", i2c_scl, 1);
      end
      $display("all tests passed");
      $finish;
   end

endmodule

// File: bench/i2c_sensor_model.sv
`timescale 1ns/1ps

module i2c_sensor_model (
   input  logic        clk,
   input  logic        scl,
   input  logic        sda,
   output logic        sda_low,
   input  int          addr_nacks,     // read address bytes to refuse
   input  int          bad_ids,        // wrong id answers before 0x88
   output logic        start_seen,
   output logic        stop_seen,
   output logic        wr_valid,
   output logic [6:0]  wr_dev,
   output logic [15:0] wr_reg,
   output logic [7:0]  wr_data,
   output int          id_reads,
   output logic        id_good_sent
);
   logic [7:0]  mem [logic [15:0]];
   logic        scl_q = 1'b1;
   logic        sda_q = 1'b1;
   logic        drive_low = 1'b0;
   logic        active = 1'b0;
   logic        reading = 1'b0;
   logic        ours = 1'b0;
   logic        have_data = 1'b0;
   logic        start_p = 1'b0;
   logic        stop_p = 1'b0;
   logic        wr_p = 1'b0;
   logic        good = 1'b0;
   logic [7:0]  sh = 8'h00;
   logic [7:0]  tx = 8'hff;
   logic [7:0]  wdata = 8'h00;
   logic [15:0] ptr = 16'h0000;
   logic [6:0]  dev = 7'h00;
   int          bit_cnt = 0;
   int          byte_cnt = 0;
   int          nacks_given = 0;
   int          bad_given = 0;
   int          reads = 0;

   assign sda_low      = drive_low;
   assign start_seen   = start_p;
   assign stop_seen    = stop_p;
   assign wr_valid     = wr_p;
   assign wr_dev       = dev;
   assign wr_reg       = ptr;
   assign wr_data      = wdata;
   assign id_reads     = reads;
   assign id_good_sent = good;

   // decode a complete byte from the master
   task automatic take_byte();
      case (byte_cnt)
         0: begin
            dev     = sh[7:1];
            reading = sh[0];
            ours    = (dev == 7'h36);
            if (!ours) begin
               active = !reading;               // follow foreign writes for the log
            end else if (reading) begin
               if (ptr == 16'h300B)
                  reads++;
               if (nacks_given < addr_nacks) begin
                  nacks_given++;
                  active = 1'b0;                // no ack, sit out the frame
               end else if (ptr == 16'h300B && bad_given < bad_ids) begin
                  bad_given++;
                  tx = 8'h40 | 8'(bad_given);
               end else if (ptr == 16'h300B) begin
                  tx   = 8'h88;
                  good = 1'b1;
               end else begin
                  tx = mem.exists(ptr) ? mem[ptr] : 8'h00;
               end
            end
         end
         1: ptr[15:8] = sh;
         2: ptr[7:0]  = sh;
         default: begin
            wdata     = sh;
            have_data = 1'b1;
         end
      endcase
   endtask

   // bus sampled mid clock, away from the dut edges
   always @(negedge clk) begin
      start_p = 1'b0;
      stop_p  = 1'b0;
      wr_p    = 1'b0;
      if (scl && scl_q && sda_q && !sda) begin
         start_p   = 1'b1;
         active    = 1'b1;
         reading   = 1'b0;
         have_data = 1'b0;
         bit_cnt   = 0;
         byte_cnt  = 0;
         drive_low = 1'b0;
      end else if (scl && scl_q && !sda_q && sda) begin
         stop_p    = 1'b1;
         active    = 1'b0;
         drive_low = 1'b0;
         if (have_data) begin
            mem[ptr] = wdata;
            wr_p     = 1'b1;
         end
         have_data = 1'b0;
      end else if (active && scl && !scl_q) begin
         if (bit_cnt == 8) begin
            bit_cnt = 0;                        // ack slot done
            byte_cnt++;
         end else begin
            sh = {sh[6:0], sda};
            bit_cnt++;
            if (bit_cnt == 8 && !reading)
               take_byte();
         end
      end else if (active && !scl && scl_q) begin
         if (bit_cnt == 8)
            drive_low = ours && !(reading && byte_cnt == 1);   // ack own bytes only
         else if (reading && byte_cnt == 1)
            drive_low = !tx[7 - bit_cnt];
         else
            drive_low = 1'b0;
      end
      scl_q = scl;
      sda_q = sda;
   end

endmodule

// File: design/cam_cfg_macros.svh
`ifndef CAM_CFG_MACROS_SVH
`define CAM_CFG_MACROS_SVH

// sensor bus address, 7-bit form
`define CAM_I2C_ADDR     7'h36

// chip id register and its expected value
`define CAM_ID_REG       16'h300B
`define CAM_ID_VALUE     8'h88

// init script size and index width
`define CFG_SCRIPT_LEN   24
`define CFG_IDX_W        5

// clocks per quarter of an scl bit
`define I2C_QUARTER      1

// idle clocks after every transaction
`define CFG_GAP_CYCLES   3

`endif

// File: design/cam_cfg_pkg.sv
package cam_cfg_pkg;

   // transaction kinds run by the i2c engine
   typedef enum logic [1:0] {
      OP_WRITE_REG,
      OP_SET_PTR,
      OP_READ_BYTE
   } i2c_op_e;

   typedef enum logic {
      ENTRY_WRITE,
      ENTRY_DELAY
   } entry_kind_e;

   typedef enum logic [3:0] {
      SEQ_IDLE,
      SEQ_ID_PTR,
      SEQ_ID_READ,
      SEQ_ID_CHECK,
      SEQ_FETCH,
      SEQ_WRITE,
      SEQ_DELAY,
      SEQ_GAP,
      SEQ_DONE
   } seq_state_e;

   typedef struct packed {
      i2c_op_e     op;
      logic [15:0] reg_addr;
      logic [7:0]  wdata;
   } i2c_cmd_t;

   typedef struct packed {
      entry_kind_e kind;
      logic [15:0] reg_addr;
      logic [7:0]  data;          // write data or delay count
   } script_entry_t;

endpackage

// File: design/camera_config_top.sv
`timescale 1ns/1ps
`include "cam_cfg_macros.svh"

module camera_config_top (
   input  logic       CLK_400K,
   input  logic       RESET_N,
   output logic       i2c_scl,
   output logic       i2c_sda_low,
   input  logic       i2c_sda_in,
   output logic [7:0] sensor_id,
   output logic       camera_released
);
   import cam_cfg_pkg::*;

   logic [`CFG_IDX_W-1:0] entry_index;
   script_entry_t         entry;
   i2c_cmd_t              cmd;
   logic                  start;
   logic                  busy;
   logic                  done;
   logic                  nack;
   logic [7:0]            rdata;

   config_sequencer u_seq (
      .CLK_400K        (CLK_400K),
      .RESET_N         (RESET_N),
      .entry_index     (entry_index),
      .entry           (entry),
      .cmd             (cmd),
      .start           (start),
      .busy            (busy),
      .done            (done),
      .nack            (nack),
      .rdata           (rdata),
      .sensor_id       (sensor_id),
      .camera_released (camera_released)
   );

   init_script_rom u_rom (
      .entry_index (entry_index),
      .entry       (entry)
   );

   i2c_xfer_engine u_eng (
      .CLK_400K    (CLK_400K),
      .RESET_N     (RESET_N),
      .cmd         (cmd),
      .start       (start),
      .busy        (busy),
      .done        (done),
      .nack        (nack),
      .rdata       (rdata),
      .i2c_scl     (i2c_scl),
      .i2c_sda_low (i2c_sda_low),
      .i2c_sda_in  (i2c_sda_in)
   );

endmodule

// File: design/config_sequencer.sv
`timescale 1ns/1ps
`include "cam_cfg_macros.svh"

module config_sequencer (
   input  logic                       CLK_400K,
   input  logic                       RESET_N,
   output logic [`CFG_IDX_W-1:0]      entry_index,
   input  cam_cfg_pkg::script_entry_t entry,
   output cam_cfg_pkg::i2c_cmd_t      cmd,
   output logic                       start,
   input  logic                       busy,
   input  logic                       done,
   input  logic                       nack,
   input  logic [7:0]                 rdata,
   output logic [7:0]                 sensor_id,
   output logic                       camera_released
);
   import cam_cfg_pkg::*;

   seq_state_e state;
   seq_state_e gap_ret;      // where to go after the gap
   logic       launched;
   logic       id_fail;
   logic [3:0] gap_cnt;
   logic [7:0] dly_cnt;
   logic       launch_ok;

   assign launch_ok = !launched && !busy;

   always_comb begin
      case (state)
         SEQ_ID_PTR:  cmd = '{op: OP_SET_PTR, reg_addr: `CAM_ID_REG, wdata: 8'h00};
         SEQ_ID_READ: cmd = '{op: OP_READ_BYTE, reg_addr: `CAM_ID_REG, wdata: 8'h00};
         default:     cmd = '{op: OP_WRITE_REG, reg_addr: entry.reg_addr, wdata: entry.data};
      endcase
   end

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state           <= SEQ_IDLE;
         gap_ret         <= SEQ_IDLE;
         launched        <= 1'b0;
         id_fail         <= 1'b0;
         gap_cnt         <= '0;
         dly_cnt         <= '0;
         start           <= 1'b0;
         entry_index     <= '0;
         sensor_id       <= '0;
         camera_released <= 1'b0;
      end else begin
         start <= 1'b0;
         case (state)
            SEQ_IDLE: begin
               id_fail <= 1'b0;
               state   <= SEQ_ID_PTR;
            end
            SEQ_ID_PTR: begin
               if (launch_ok) begin
                  start    <= 1'b1;
                  launched <= 1'b1;
               end
               if (done) begin
                  launched <= 1'b0;
                  id_fail  <= nack;
                  gap_ret  <= SEQ_ID_READ;
                  state    <= SEQ_GAP;
               end
            end
            SEQ_ID_READ: begin
               if (launch_ok) begin
                  start    <= 1'b1;
                  launched <= 1'b1;
               end
               if (done) begin
                  launched <= 1'b0;
                  id_fail  <= id_fail | nack;
                  state    <= SEQ_ID_CHECK;
               end
            end
            SEQ_ID_CHECK: begin
               if (id_fail || rdata != `CAM_ID_VALUE) begin
                  gap_ret <= SEQ_IDLE;             // retry whole id phase
               end else begin
                  sensor_id   <= rdata;
                  entry_index <= '0;
                  gap_ret     <= SEQ_FETCH;
               end
               state <= SEQ_GAP;
            end
            SEQ_FETCH: begin
               if (entry_index == `CFG_IDX_W'(`CFG_SCRIPT_LEN)) begin
                  state <= SEQ_DONE;
               end else if (entry.kind == ENTRY_DELAY) begin
                  dly_cnt <= '0;
                  state   <= SEQ_DELAY;
               end else begin
                  state <= SEQ_WRITE;
               end
            end
            SEQ_WRITE: begin
               if (launch_ok) begin
                  start    <= 1'b1;
                  launched <= 1'b1;
               end
               if (done) begin                     // write nack ignored
                  launched    <= 1'b0;
                  entry_index <= entry_index + 1'b1;
                  gap_ret     <= SEQ_FETCH;
                  state       <= SEQ_GAP;
               end
            end
            SEQ_DELAY: begin
               if (dly_cnt == entry.data) begin
                  entry_index <= entry_index + 1'b1;
                  state       <= SEQ_FETCH;
               end else begin
                  dly_cnt <= dly_cnt + 8'd1;
               end
            end
            SEQ_GAP: begin
               if (gap_cnt == 4'(`CFG_GAP_CYCLES - 1)) begin
                  gap_cnt <= '0;
                  state   <= gap_ret;
               end else begin
                  gap_cnt <= gap_cnt + 4'd1;
               end
            end
            SEQ_DONE: camera_released <= 1'b1;    // parked here
            default:  state <= SEQ_IDLE;
         endcase
      end
   end

endmodule

// File: design/i2c_xfer_engine.sv
`timescale 1ns/1ps
`include "cam_cfg_macros.svh"

module i2c_xfer_engine (
   input  logic                  CLK_400K,
   input  logic                  RESET_N,
   input  cam_cfg_pkg::i2c_cmd_t cmd,
   input  logic                  start,
   output logic                  busy,
   output logic                  done,
   output logic                  nack,
   output logic [7:0]            rdata,
   output logic                  i2c_scl,
   output logic                  i2c_sda_low,
   input  logic                  i2c_sda_in
);
   import cam_cfg_pkg::*;

   typedef enum logic [1:0] {
      E_IDLE,
      E_START,
      E_BITS,
      E_STOP
   } eng_state_e;

   eng_state_e state;
   i2c_cmd_t   cmd_q;        // held for the whole transaction
   logic [3:0] tick_cnt;
   logic [1:0] quarter;
   logic [3:0] bit_cnt;      // 0..7 data, 8 is the ack slot
   logic [1:0] byte_cnt;
   logic [1:0] last_byte;
   logic [7:0] shift;
   logic       samp;         // sda sampled on rising scl
   logic       q_end;
   logic       rd_byte;

   function automatic logic [7:0] tx_byte(input i2c_cmd_t c, input logic [1:0] idx);
      logic [7:0] b;
      case (idx)
         2'd0:    b = {`CAM_I2C_ADDR, c.op == OP_READ_BYTE};   // address plus r/w bit
         2'd1:    b = c.reg_addr[15:8];
         2'd2:    b = c.reg_addr[7:0];
         default: b = c.wdata;
      endcase
      return b;
   endfunction

   always_comb begin
      case (cmd_q.op)
         OP_WRITE_REG: last_byte = 2'd3;
         OP_SET_PTR:   last_byte = 2'd2;
         default:      last_byte = 2'd1;
      endcase
   end

   assign q_end   = (tick_cnt == 4'(`I2C_QUARTER - 1));
   assign rd_byte = (cmd_q.op == OP_READ_BYTE) && (byte_cnt == 2'd1);
   assign busy    = (state != E_IDLE);

   // bit timing and frame control
   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state    <= E_IDLE;
         tick_cnt <= '0;
         quarter  <= '0;
         bit_cnt  <= '0;
         byte_cnt <= '0;
         done     <= 1'b0;
         nack     <= 1'b0;
      end else begin
         done <= 1'b0;
         if (state == E_IDLE) begin
            tick_cnt <= '0;
            quarter  <= '0;
            if (start) begin
               state    <= E_START;
               bit_cnt  <= '0;
               byte_cnt <= '0;
               nack     <= 1'b0;
            end
         end else if (!q_end) begin
            tick_cnt <= tick_cnt + 4'd1;
         end else begin
            tick_cnt <= '0;
            quarter  <= quarter + 2'd1;
            if (state == E_BITS && quarter == 2'd1 && bit_cnt == 4'd8 && !rd_byte)
               nack <= nack | i2c_sda_in;     // slave ack slot
            if (quarter == 2'd3) begin
               case (state)
                  E_START: state <= E_BITS;
                  E_BITS: begin
                     if (bit_cnt == 4'd8) begin
                        bit_cnt <= '0;
                        if (byte_cnt == last_byte)
                           state <= E_STOP;
                        else
                           byte_cnt <= byte_cnt + 2'd1;
                     end else begin
                        bit_cnt <= bit_cnt + 4'd1;
                     end
                  end
                  E_STOP: begin
                     state <= E_IDLE;
                     done  <= 1'b1;
                  end
                  default: state <= E_IDLE;
               endcase
            end
         end
      end
   end

   // shift register, tx load and rx capture
   always_ff @(posedge CLK_400K) begin
      if (state == E_IDLE && start) begin
         cmd_q <= cmd;
         shift <= tx_byte(cmd, 2'd0);
      end else if (state == E_BITS && q_end) begin
         if (quarter == 2'd1)
            samp <= i2c_sda_in;
         if (quarter == 2'd3) begin
            if (bit_cnt < 4'd8)
               shift <= {shift[6:0], samp};
            else if (byte_cnt != last_byte)
               shift <= tx_byte(cmd_q, byte_cnt + 2'd1);
            else if (rd_byte)
               rdata <= shift;             // read byte complete
         end
      end
   end

   // pin decode from state and quarter
   always_comb begin
      i2c_scl     = 1'b1;
      i2c_sda_low = 1'b0;
      case (state)
         E_START: begin
            i2c_scl     = (quarter != 2'd3);
            i2c_sda_low = (quarter != 2'd0);   // sda falls while scl high
         end
         E_BITS: begin
            i2c_scl     = (quarter == 2'd1) || (quarter == 2'd2);
            i2c_sda_low = (bit_cnt < 4'd8) && !rd_byte && !shift[7];
         end
         E_STOP: begin
            i2c_scl     = (quarter != 2'd0);
            i2c_sda_low = (quarter < 2'd2);    // sda rises while scl high
         end
         default: ;
      endcase
   end

endmodule

// File: design/init_script_rom.sv
`timescale 1ns/1ps
`include "cam_cfg_macros.svh"

module init_script_rom (
   input  logic [`CFG_IDX_W-1:0]      entry_index,
   output cam_cfg_pkg::script_entry_t entry
);
   import cam_cfg_pkg::*;

   function automatic script_entry_t wr(input logic [15:0] a, input logic [7:0] d);
      return '{kind: ENTRY_WRITE, reg_addr: a, data: d};
   endfunction

   function automatic script_entry_t dly(input logic [7:0] n);
      return '{kind: ENTRY_DELAY, reg_addr: 16'h0000, data: n};
   endfunction

   always_comb begin
      case (entry_index)
         5'd0:    entry = wr(16'h0103, 8'h01);   // software reset
         5'd1:    entry = wr(16'h0103, 8'h01);
         5'd2:    entry = dly(8'd10);
         5'd3:    entry = wr(16'h0100, 8'h00);   // standby
         5'd4:    entry = wr(16'h0100, 8'h00);
         5'd5:    entry = wr(16'h0302, 8'd24);   // pll1 multiplier
         5'd6:    entry = wr(16'h0303, 8'h00);
         5'd7:    entry = wr(16'h0304, 8'd3);    // pll1 mipi div
         5'd8:    entry = wr(16'h030e, 8'h00);
         5'd9:    entry = wr(16'h030f, 8'h04);
         5'd10:   entry = wr(16'h0312, 8'h01);
         5'd11:   entry = wr(16'h031e, 8'h0c);
         5'd12:   entry = wr(16'h3015, 8'h01);   // clock div
         5'd13:   entry = wr(16'h3808, 8'h02);   // x size 640
         5'd14:   entry = wr(16'h3809, 8'h80);
         5'd15:   entry = wr(16'h380a, 8'h01);   // y size 480
         5'd16:   entry = wr(16'h380b, 8'he0);
         5'd17:   entry = wr(16'h5018, 8'h19);   // red gain
         5'd18:   entry = wr(16'h501a, 8'h10);   // green gain
         5'd19:   entry = wr(16'h501c, 8'h17);   // blue gain
         5'd20:   entry = dly(8'd10);
         5'd21:   entry = wr(16'h5000, 8'h16);   // mwb, bpc, wpc on
         5'd22:   entry = wr(16'h5001, 8'h01);   // blc on
         5'd23:   entry = wr(16'h0100, 8'h01);   // streaming
         default: entry = dly(8'd0);
      endcase
   end

endmodule

// File: sim.f
+incdir+design
design/cam_cfg_pkg.sv
design/i2c_xfer_engine.sv
design/init_script_rom.sv
design/config_sequencer.sv
design/camera_config_top.sv
bench/i2c_sensor_model.sv
bench/camera_config_tb.sv
